// File: sim/datapath_golden.txt
// Columns: tag address data. Tag 1 program word, 2 initial data word,
// 3 expected store in order, 4 expected store count (address unused)
1 00000000 24010100
1 00000004 24020007
1 00000008 2403fffd
1 0000000c 3c041234
1 00000010 34845678
1 00000014 00432821
1 00000018 00623023
1 0000001c 00863826
1 00000020 00e34024
1 00000024 00a44825
1 00000028 0062502a
1 0000002c 00025900
1 00000030 ac250000
1 00000034 ac270004
1 00000038 ac280008
1 0000003c ac29000c
1 00000040 ac2a0010
1 00000044 ac2b0014
1 00000048 8c2c0100
1 0000004c 01826821
1 00000050 ac2d0018
1 00000054 ac24001c
1 00000058 8c2e001c
1 0000005c 01c57823
1 00000060 ac2f0020
1 00000064 24100001
1 00000068 120a0001
1 0000006c ac220024
1 00000070 160a0001
1 00000074 ac300024
1 00000078 16000001
1 0000007c ac220028
1 00000080 12000001
1 00000084 08000023
1 00000088 ac22002c
1 0000008c ac230028
1 00000090 fc000000
1 00000094 ac220030
2 00000200 0badf00d
3 00000100 00000004
3 00000104 edcba98e
3 00000108 edcba98c
3 0000010c 1234567c
3 00000110 00000001
3 00000114 00000070
3 00000118 0badf014
3 0000011c 12345678
3 00000120 12345674
3 00000124 00000001
3 00000128 fffffffd
4 00000000 0000000b

// File: list.f
src/mips_pkg.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/hazard_forward_unit.sv
src/datapath.sv
sim/datapath_chk.sv
sim/datapath_tb.sv

// File: Bender.yml
package:
  name: mips3_datapath

sources:
  - files:
      - src/mips_pkg.sv
      - src/register_file.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/result_stage.sv
      - src/hazard_forward_unit.sv
      - src/datapath.sv
  - target: simulation
    files:
      - sim/datapath_chk.sv
      - sim/datapath_tb.sv

// File: sim/datapath_tb.sv
// Testbench for the three-stage MIPS datapath
// Models the instruction and data memories with random hit gaps, loads the
// program and initial data from the golden file and stops on halt or timeout
`timescale 1ns/100ps

module datapath_tb;

  localparam logic [31:0] PC_INIT    = 32'h0;
  localparam int          GOLD_WORDS = 300;

  logic        CLK = 1'b0;
  logic        nRST;
  logic        imem_ren;
  logic [31:0] imem_addr;
  logic [31:0] imem_load;
  logic        ihit;
  logic        dmem_ren;
  logic        dmem_wen;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_store;
  logic [31:0] dmem_load;
  logic        dhit;
  logic        halt;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] gold [GOLD_WORDS];
  logic [31:0] rnd_state = 32'h1d8;
  int          prog_words;
  int          watchdog_cycles;
  int          checked;
  int          errors;
  int          total_errors;
  logic        finished;

  datapath #(.PC_INIT(PC_INIT)) dut0 (
    .CLK,
    .nRST,
    .imem_ren,
    .imem_addr,
    .imem_load,
    .ihit,
    .dmem_ren,
    .dmem_wen,
    .dmem_addr,
    .dmem_store,
    .dmem_load,
    .dhit,
    .halt
  );

  datapath_chk chk0 (
    .CLK,
    .nRST,
    .dmem_wen,
    .dhit,
    .dmem_addr,
    .dmem_store,
    .halt,
    .checked,
    .errors,
    .finished
  );

  initial begin
    forever #5 CLK = ~CLK;
  end

  // LCG step for the hit gaps
  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic load_memories;
    int k;
    for (k = 0; k < 256; k++) begin
      // Unused opcode 0x3e decodes as a bubble
      imem[k] = 32'hf8000000 | (k << 2);
      dmem[k] = 32'hd0000000 | (k << 2);
    end
    for (k = 0; k < GOLD_WORDS; k++)
      gold[k] = '0;
    $readmemh("sim/datapath_golden.txt", gold);
    prog_words = 0;
    for (k = 0; k < GOLD_WORDS; k += 3) begin
      if (gold[k] == 32'd1) begin
        imem[gold[k+1][9:2]] = gold[k+2];
        prog_words++;
      end else if (gold[k] == 32'd2) begin
        dmem[gold[k+1][9:2]] = gold[k+2];
      end
    end
  endtask

  // Memory responses, about one hit in four held low
  always @(negedge CLK) begin : drive_memories
    logic ihit_next;
    logic dhit_next;
    rnd_state = next_random(rnd_state);
    ihit_next = rnd_state[31:30] != 2'b00;
    rnd_state = next_random(rnd_state);
    dhit_next = rnd_state[31:30] != 2'b00;
    // Write lands at the coming rising edge
    if (dmem_wen && dhit_next)
      dmem[dmem_addr[9:2]] = dmem_store;
    ihit      <= ihit_next;
    dhit      <= dhit_next;
    imem_load <= imem[imem_addr[9:2]];
    dmem_load <= dmem[dmem_addr[9:2]];
  end

  initial begin
    nRST      = 1'b0;
    ihit      = 1'b0;
    dhit      = 1'b0;
    imem_load = '0;
    dmem_load = '0;
    load_memories();
    repeat (16) @(negedge CLK);
    nRST = 1'b1;
    wait (finished);
    // Let a stray store after halt show up
    repeat (4) @(negedge CLK);
    total_errors = errors + dut0.props0.fail_count;
    $display("Summary: %0d stores checked, %0d errors, %0d assertion failures",
             checked, errors, dut0.props0.fail_count);
    if (total_errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial begin
    @(posedge nRST);
    watchdog_cycles = prog_words * 40 * 4;
    repeat (watchdog_cycles) @(posedge CLK);
    $display("Timeout: the processor did not halt within %0d cycles", watchdog_cycles);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: sim/datapath_chk.sv
// Scoreboard for the datapath: compares every completed data store and
// the final halt against the expected sequence in the golden file.
// Also holds the port protocol assertions bound into the DUT.
`timescale 1ns/100ps

module datapath_chk (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        dmem_wen,
  input  logic        dhit,
  input  logic [31:0] dmem_addr,
  input  logic [31:0] dmem_store,
  input  logic        halt,
  output int          checked,
  output int          errors,
  output logic        finished
);

  localparam int GOLD_WORDS = 300;

  logic [31:0] gold [GOLD_WORDS];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          exp_count;

  initial begin : read_expected
    int k;
    checked   = 0;
    errors    = 0;
    finished  = 1'b0;
    exp_count = 0;
    for (k = 0; k < GOLD_WORDS; k++)
      gold[k] = '0;
    $readmemh("sim/datapath_golden.txt", gold);
    for (k = 0; k < GOLD_WORDS; k += 3) begin
      if (gold[k] == 32'd3) begin
        exp_addr.push_back(gold[k+1]);
        exp_data.push_back(gold[k+2]);
      end else if (gold[k] == 32'd4) begin
        exp_count = gold[k+2];
      end
    end
  end

  task automatic compare_store(input logic [31:0] addr, input logic [31:0] data);
    if (addr !== exp_addr[checked]) begin
      $display("Error: dmem_addr of store %0d expected 0x%08h, got 0x%08h",
               checked, exp_addr[checked], addr);
      errors++;
    end else if (data !== exp_data[checked]) begin
      $display("Error: dmem_store of store %0d expected 0x%08h, got 0x%08h",
               checked, exp_data[checked], data);
      errors++;
    end else begin
      $display("Store %0d: [0x%08h] = 0x%08h ok", checked, addr, data);
    end
  endtask

  // Signals are taken as they stood just before the edge
  always @(posedge CLK) begin
    if (nRST && dmem_wen && dhit) begin
      if (halt) begin
        $display("A store to 0x%08h completed after halt", dmem_addr);
        errors++;
      end else if (checked >= exp_addr.size()) begin
        $display("An extra store to 0x%08h with data 0x%08h was not expected",
                 dmem_addr, dmem_store);
        errors++;
      end else begin
        compare_store(dmem_addr, dmem_store);
      end
      checked++;
    end
    if (nRST && halt && !finished) begin
      if (checked != exp_count) begin
        $display("Halt came after %0d stores but %0d were expected", checked, exp_count);
        errors++;
      end else begin
        $display("Halt: raised after %0d stores", checked);
      end
      finished = 1'b1;
    end
  end

endmodule

module pipeline_props (
  input logic        CLK,
  input logic        nRST,
  input logic        imem_ren,
  input logic [31:0] imem_addr,
  input logic        ihit,
  input logic        dmem_ren,
  input logic        dmem_wen,
  input logic [31:0] dmem_addr,
  input logic [31:0] dmem_store,
  input logic        dhit,
  input logic        halt
);

  int fail_count = 0;

  a_strobes_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_ren && dmem_wen))
    else begin
      $error("data read and write strobes high together");
      fail_count++;
    end

  // A halted processor keeps halt and leaves both memory ports idle
  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> (halt && !imem_ren && !dmem_ren && !dmem_wen))
    else begin
      $error("halt fell or a memory strobe rose after halt");
      fail_count++;
    end

  a_dread_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (dmem_ren && !dhit) |=> (dmem_ren && $stable(dmem_addr)))
    else begin
      $error("data read strobe or address changed before dhit");
      fail_count++;
    end

  a_dwrite_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (dmem_wen && !dhit) |=> (dmem_wen && $stable(dmem_addr) && $stable(dmem_store)))
    else begin
      $error("data write strobe, address or data changed before dhit");
      fail_count++;
    end

  // Fetch may drop only when halt stops the processor
  a_fetch_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (imem_ren && !ihit) |=> (halt || (imem_ren && $stable(imem_addr))))
    else begin
      $error("fetch strobe or address changed before ihit");
      fail_count++;
    end

endmodule

bind datapath pipeline_props props0 (
  .CLK,
  .nRST,
  .imem_ren,
  .imem_addr,
  .ihit,
  .dmem_ren,
  .dmem_wen,
  .dmem_addr,
  .dmem_store,
  .dhit,
  .halt
);

// File: src/datapath.sv
// Top level of the three-stage MIPS datapath
// Connects decode, execute, result and the hazard unit to the
// instruction and data memory ports
`timescale 1ns/100ps

module datapath import mips_pkg::*; #(
  parameter word_t PC_INIT = '0
) (
  input  logic  CLK,
  input  logic  nRST,
  output logic  imem_ren,
  output word_t imem_addr,
  input  word_t imem_load,
  input  logic  ihit,
  output logic  dmem_ren,
  output logic  dmem_wen,
  output word_t dmem_addr,
  output word_t dmem_store,
  input  word_t dmem_load,
  input  logic  dhit,
  output logic  halt
);

  logic    freeze, flush, redirect, fwd_rs, fwd_rt, wb_en;
  word_t   redirect_pc, wb_data;
  regsel_t wb_dest, rs_ex, rt_ex;

  // Decode to execute
  aluop_t  dec_alu_op;
  word_t   dec_rs_val, dec_rt_val, dec_imm, dec_pc_next;
  regsel_t dec_rs, dec_rt, dec_dest;
  logic    dec_mem_read, dec_mem_write, dec_reg_write;
  logic    dec_is_branch_eq, dec_is_branch_ne, dec_is_jump, dec_is_halt;

  // Execute to result
  word_t   ex_alu_result, ex_store_data;
  regsel_t ex_dest;
  logic    ex_mem_read, ex_mem_write, ex_reg_write, ex_is_halt;

  decode_stage #(.PC_INIT(PC_INIT)) dec0 (
    .CLK, .nRST, .freeze, .flush, .halt, .redirect_pc,
    .imem_load, .imem_addr, .imem_ren, .wb_en, .wb_dest, .wb_data,
    .alu_op (dec_alu_op), .rs_val (dec_rs_val), .rt_val (dec_rt_val),
    .rs (dec_rs), .rt (dec_rt), .imm (dec_imm), .dest (dec_dest),
    .mem_read (dec_mem_read), .mem_write (dec_mem_write),
    .reg_write (dec_reg_write), .is_branch_eq (dec_is_branch_eq),
    .is_branch_ne (dec_is_branch_ne), .is_jump (dec_is_jump),
    .is_halt (dec_is_halt), .pc_next (dec_pc_next)
  );

  execute_stage ex0 (
    .CLK, .nRST, .freeze,
    .dec_alu_op, .dec_rs_val, .dec_rt_val, .dec_rs, .dec_rt, .dec_imm,
    .dec_dest, .dec_mem_read, .dec_mem_write, .dec_reg_write,
    .dec_is_branch_eq, .dec_is_branch_ne, .dec_is_jump, .dec_is_halt,
    .dec_pc_next, .wb_data, .fwd_rs, .fwd_rt,
    .alu_result (ex_alu_result), .store_data (ex_store_data), .dest (ex_dest),
    .mem_read (ex_mem_read), .mem_write (ex_mem_write),
    .reg_write (ex_reg_write), .is_halt (ex_is_halt),
    .redirect, .redirect_pc, .rs_ex, .rt_ex
  );

  result_stage res0 (
    .CLK, .nRST, .freeze, .dhit,
    .alu_result (ex_alu_result), .store_data (ex_store_data), .dest (ex_dest),
    .mem_read (ex_mem_read), .mem_write (ex_mem_write),
    .reg_write (ex_reg_write), .is_halt (ex_is_halt),
    .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .dmem_load,
    .wb_en, .wb_dest, .wb_data, .halt
  );

  hazard_forward_unit hfu0 (
    .imem_ren, .ihit, .dmem_ren, .dmem_wen, .dhit, .redirect,
    .wb_en, .wb_dest, .rs_ex, .rt_ex,
    .freeze, .flush, .fwd_rs, .fwd_rt
  );

endmodule

// File: src/hazard_forward_unit.sv
// Pipeline control: global freeze on memory stalls, flush on redirect
// and the writeback-to-execute forwarding selects
`timescale 1ns/100ps

module hazard_forward_unit import mips_pkg::*; (
  input  logic    imem_ren,
  input  logic    ihit,
  input  logic    dmem_ren,
  input  logic    dmem_wen,
  input  logic    dhit,
  input  logic    redirect,
  input  logic    wb_en,
  input  regsel_t wb_dest,
  input  regsel_t rs_ex,
  input  regsel_t rt_ex,
  output logic    freeze,
  output logic    flush,
  output logic    fwd_rs,
  output logic    fwd_rt
);

  logic fetch_wait;
  logic data_wait;

  assign fetch_wait = imem_ren && !ihit;
  assign data_wait  = (dmem_ren || dmem_wen) && !dhit;
  assign freeze     = fetch_wait || data_wait;

  assign flush = redirect && !freeze;

  // Register 0 is never forwarded
  assign fwd_rs = wb_en && (wb_dest != '0) && (wb_dest == rs_ex);
  assign fwd_rt = wb_en && (wb_dest != '0) && (wb_dest == rt_ex);

endmodule

// File: src/result_stage.sv
// Third stage: data memory access and writeback selection
// Also keeps the sticky halt flag once a HALT arrives
`timescale 1ns/100ps

module result_stage import mips_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    freeze,
  input  logic    dhit,
  input  word_t   alu_result,
  input  word_t   store_data,
  input  regsel_t dest,
  input  logic    mem_read,
  input  logic    mem_write,
  input  logic    reg_write,
  input  logic    is_halt,
  output logic    dmem_ren,
  output logic    dmem_wen,
  output word_t   dmem_addr,
  output word_t   dmem_store,
  input  word_t   dmem_load,
  output logic    wb_en,
  output regsel_t wb_dest,
  output word_t   wb_data,
  output logic    halt
);

  // Access finished while the pipeline was held by a fetch stall
  logic  mem_done;
  word_t load_q;

  assign dmem_ren   = mem_read && !mem_done;
  assign dmem_wen   = mem_write && !mem_done;
  assign dmem_addr  = alu_result;
  assign dmem_store = store_data;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mem_done <= 1'b0;
      halt     <= 1'b0;
    end else begin
      if (!freeze)
        mem_done <= 1'b0;
      else if ((dmem_ren || dmem_wen) && dhit)
        mem_done <= 1'b1;
      if (is_halt)
        halt <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (dmem_ren && dhit)
      load_q <= dmem_load;
  end

  // Written only on the advancing edge, so once per instruction
  assign wb_en   = reg_write && !freeze;
  assign wb_dest = dest;
  assign wb_data = !mem_read ? alu_result : (mem_done ? load_q : dmem_load);

endmodule

// File: src/execute_stage.sv
// Second stage: operand forwarding, ALU and branch resolution
// Holds the decoded instruction and the register feeding the result stage
`timescale 1ns/100ps

module execute_stage import mips_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    freeze,
  input  aluop_t  dec_alu_op,
  input  word_t   dec_rs_val,
  input  word_t   dec_rt_val,
  input  regsel_t dec_rs,
  input  regsel_t dec_rt,
  input  word_t   dec_imm,
  input  regsel_t dec_dest,
  input  logic    dec_mem_read,
  input  logic    dec_mem_write,
  input  logic    dec_reg_write,
  input  logic    dec_is_branch_eq,
  input  logic    dec_is_branch_ne,
  input  logic    dec_is_jump,
  input  logic    dec_is_halt,
  input  word_t   dec_pc_next,
  input  word_t   wb_data,
  input  logic    fwd_rs,
  input  logic    fwd_rt,
  output word_t   alu_result,
  output word_t   store_data,
  output regsel_t dest,
  output logic    mem_read,
  output logic    mem_write,
  output logic    reg_write,
  output logic    is_halt,
  output logic    redirect,
  output word_t   redirect_pc,
  output regsel_t rs_ex,
  output regsel_t rt_ex
);

  aluop_t  op_q;
  word_t   rs_val_q, rt_val_q, imm_q, pc_next_q;
  regsel_t dest_q;
  logic    mem_read_q, mem_write_q, reg_write_q;
  logic    beq_q, bne_q, jump_q, halt_q;
  word_t   a, b, rt_op, alu_out;
  logic    taken;

  // Decoded instruction; a taken redirect squashes the wrong-path one
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      {mem_read_q, mem_write_q, reg_write_q} <= '0;
      {beq_q, bne_q, jump_q, halt_q} <= '0;
      rs_ex <= '0;
      rt_ex <= '0;
    end else if (!freeze) begin
      if (redirect) begin
        {mem_read_q, mem_write_q, reg_write_q} <= '0;
        {beq_q, bne_q, jump_q, halt_q} <= '0;
        rs_ex <= '0;
        rt_ex <= '0;
      end else begin
        mem_read_q  <= dec_mem_read;
        mem_write_q <= dec_mem_write;
        reg_write_q <= dec_reg_write;
        beq_q       <= dec_is_branch_eq;
        bne_q       <= dec_is_branch_ne;
        jump_q      <= dec_is_jump;
        halt_q      <= dec_is_halt;
        rs_ex       <= dec_rs;
        rt_ex       <= dec_rt;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!freeze) begin
      op_q      <= dec_alu_op;
      rs_val_q  <= dec_rs_val;
      rt_val_q  <= dec_rt_val;
      imm_q     <= dec_imm;
      pc_next_q <= dec_pc_next;
      dest_q    <= dec_dest;
    end
  end

  assign a     = fwd_rs ? wb_data : rs_val_q;
  assign rt_op = fwd_rt ? wb_data : rt_val_q;
  // Stores add the offset while rt stays the store data
  assign b     = mem_write_q ? imm_q : rt_op;

  always_comb begin
    case (op_q)
      ALU_ADD: alu_out = a + b;
      ALU_SUB: alu_out = a - b;
      ALU_AND: alu_out = a & b;
      ALU_OR:  alu_out = a | b;
      ALU_XOR: alu_out = a ^ b;
      ALU_SLT: alu_out = {31'd0, $signed(a) < $signed(b)};
      ALU_SLL: alu_out = b << imm_q[4:0];
      ALU_LUI: alu_out = {imm_q[15:0], 16'd0};
      default: alu_out = a + b;
    endcase
  end

  assign taken = (beq_q && a == rt_op) || (bne_q && a != rt_op) || jump_q;
  assign redirect = taken && !freeze;
  assign redirect_pc = jump_q ? {pc_next_q[31:28], imm_q[25:0], 2'b00}
                              : pc_next_q + {imm_q[29:0], 2'b00};

  // Result stage input; a HALT stays parked here
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      {mem_read, mem_write, reg_write, is_halt} <= '0;
      dest <= '0;
    end else if (!freeze && !is_halt) begin
      mem_read  <= mem_read_q;
      mem_write <= mem_write_q;
      reg_write <= reg_write_q;
      is_halt   <= halt_q;
      dest      <= dest_q;
    end
  end

  always_ff @(posedge CLK) begin
    if (!freeze && !is_halt) begin
      alu_result <= alu_out;
      store_data <= rt_op;
    end
  end

endmodule

// File: src/decode_stage.sv
// First stage: program counter, fetch register and instruction decode
// Presents decoded control and register operands to the execute stage
`timescale 1ns/100ps

module decode_stage import mips_pkg::*; #(
  parameter word_t PC_INIT = '0
) (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    freeze,
  input  logic    flush,
  input  logic    halt,
  input  word_t   redirect_pc,
  input  word_t   imem_load,
  output word_t   imem_addr,
  output logic    imem_ren,
  input  logic    wb_en,
  input  regsel_t wb_dest,
  input  word_t   wb_data,
  output aluop_t  alu_op,
  output word_t   rs_val,
  output word_t   rt_val,
  output regsel_t rs,
  output regsel_t rt,
  output word_t   imm,
  output regsel_t dest,
  output logic    mem_read,
  output logic    mem_write,
  output logic    reg_write,
  output logic    is_branch_eq,
  output logic    is_branch_ne,
  output logic    is_jump,
  output logic    is_halt,
  output word_t   pc_next
);

  word_t  pc;
  instr_t instr;
  word_t  rs_rdat;
  word_t  rt_rdat;
  logic   imm_on_rt;

  assign imem_ren  = !halt;
  assign imem_addr = pc;
  // PC already points past the instruction held here
  assign pc_next   = pc;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc    <= PC_INIT;
      instr <= '0;
    end else if (!freeze && !halt) begin
      if (flush) begin
        pc    <= redirect_pc;
        instr <= '0;
      end else begin
        pc    <= pc + 32'd4;
        instr <= imem_load;
      end
    end
  end

  register_file rf0 (
    .CLK,
    .nRST,
    .wen   (wb_en),
    .wsel  (wb_dest),
    .wdat  (wb_data),
    .rsel1 (instr.i.rs),
    .rsel2 (instr.i.rt),
    .rdat1 (rs_rdat),
    .rdat2 (rt_rdat)
  );

  always_comb begin
    alu_op       = ALU_ADD;
    imm          = {{16{instr.i.imm[15]}}, instr.i.imm};
    dest         = instr.i.rt;
    imm_on_rt    = 1'b0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    reg_write    = 1'b0;
    is_branch_eq = 1'b0;
    is_branch_ne = 1'b0;
    is_jump      = 1'b0;
    is_halt      = 1'b0;
    case (instr.i.opcode)
      RTYPE: begin
        dest      = instr.r.rd;
        reg_write = 1'b1;
        case (instr.r.funct)
          ADDU: alu_op = ALU_ADD;
          SUBU: alu_op = ALU_SUB;
          AND:  alu_op = ALU_AND;
          OR:   alu_op = ALU_OR;
          XOR:  alu_op = ALU_XOR;
          SLT:  alu_op = ALU_SLT;
          SLL: begin
            alu_op = ALU_SLL;
            imm    = {27'd0, instr.r.shamt};
          end
          default: reg_write = 1'b0;
        endcase
      end
      ADDIU: begin
        reg_write = 1'b1;
        imm_on_rt = 1'b1;
      end
      ANDI: begin
        alu_op    = ALU_AND;
        imm       = {16'd0, instr.i.imm};
        reg_write = 1'b1;
        imm_on_rt = 1'b1;
      end
      ORI: begin
        alu_op    = ALU_OR;
        imm       = {16'd0, instr.i.imm};
        reg_write = 1'b1;
        imm_on_rt = 1'b1;
      end
      LUI: begin
        alu_op    = ALU_LUI;
        reg_write = 1'b1;
        imm_on_rt = 1'b1;
      end
      LW: begin
        mem_read  = 1'b1;
        reg_write = 1'b1;
        imm_on_rt = 1'b1;
      end
      SW:   mem_write    = 1'b1;
      BEQ:  is_branch_eq = 1'b1;
      BNE:  is_branch_ne = 1'b1;
      J: begin
        is_jump = 1'b1;
        // 26-bit target spans rs, rt and the immediate
        imm     = {6'd0, instr.i.rs, instr.i.rt, instr.i.imm};
      end
      HALT: is_halt = 1'b1;
      default: ;
    endcase
  end

  // Immediate ALU ops carry the immediate as operand B, index 0 keeps it unforwarded
  assign rs     = instr.i.rs;
  assign rt     = imm_on_rt ? '0 : instr.i.rt;
  assign rs_val = rs_rdat;
  assign rt_val = imm_on_rt ? imm : rt_rdat;

endmodule

// File: src/register_file.sv
// General purpose register file, two read ports and one write port
// Register 0 always reads zero; a same-cycle write is seen by the reads
`timescale 1ns/100ps

module register_file import mips_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    wen,
  input  regsel_t wsel,
  input  word_t   wdat,
  input  regsel_t rsel1,
  input  regsel_t rsel2,
  output word_t   rdat1,
  output word_t   rdat2
);

  word_t regs [32];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // Write-through so decode sees the value retiring this cycle
  always_comb begin
    if (rsel1 == '0)
      rdat1 = '0;
    else if (wen && wsel == rsel1)
      rdat1 = wdat;
    else
      rdat1 = regs[rsel1];
  end

  always_comb begin
    if (rsel2 == '0)
      rdat2 = '0;
    else if (wen && wsel == rsel2)
      rdat2 = wdat;
    else
      rdat2 = regs[rsel2];
  end

endmodule

// File: src/mips_pkg.sv
// Types and encodings shared by the three-stage MIPS datapath
// Every RTL module pulls these in with a wildcard import in its header
package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regsel_t;

  // Primary opcodes of the supported subset
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // R-type function codes
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,
    ALU_SLL = 3'd6,
    ALU_LUI = 3'd7
  } aluop_t;

  typedef struct packed {
    opcode_t     opcode;
    regsel_t     rs;
    regsel_t     rt;
    regsel_t     rd;
    logic [4:0]  shamt;
    funct_t      funct;
  } r_view_t;

  typedef struct packed {
    opcode_t     opcode;
    regsel_t     rs;
    regsel_t     rt;
    logic [15:0] imm;
  } i_view_t;

  // One instruction word, read as R-type or I-type by opcode
  typedef union packed {
    r_view_t r;
    i_view_t i;
  } instr_t;

endpackage
